/* src/board_pkg.sv */
package board_pkg;

    localparam int w_digit = 4;   // Display digits
    localparam int w_seg   = 8;   // Segments a to g plus point
    localparam int w_mic   = 24;  // INMP441 sample width
    localparam int w_sound = 16;  // Audio output sample width
    localparam int w_bar   = 6;   // Level bar LEDs

    // Bit 7 is segment a, bit 1 is segment g, bit 0 is the point

    function automatic logic [w_seg - 1:0] seg_hex_font (input logic [3:0] nibble);
        case (nibble)
            4'h0: seg_hex_font = 8'b1111_1100;
            4'h1: seg_hex_font = 8'b0110_0000;
            4'h2: seg_hex_font = 8'b1101_1010;
            4'h3: seg_hex_font = 8'b1111_0010;
            4'h4: seg_hex_font = 8'b0110_0110;
            4'h5: seg_hex_font = 8'b1011_0110;
            4'h6: seg_hex_font = 8'b1011_1110;
            4'h7: seg_hex_font = 8'b1110_0000;
            4'h8: seg_hex_font = 8'b1111_1110;
            4'h9: seg_hex_font = 8'b1111_0110;
            4'ha: seg_hex_font = 8'b1110_1110;
            4'hb: seg_hex_font = 8'b0011_1110;  // Lower case b
            4'hc: seg_hex_font = 8'b1001_1100;
            4'hd: seg_hex_font = 8'b0111_1010;  // Lower case d
            4'he: seg_hex_font = 8'b1001_1110;
            default: seg_hex_font = 8'b1000_1110;  // F
        endcase
    endfunction

endpackage

/* src/inmp441_mic_i2s_receiver.sv */
`timescale 1ns/1ns

module inmp441_mic_i2s_receiver
#(
    parameter clk_mhz = 50
)
(
    input                                 clk,
    input                                 rst,
    input                                 sd,
    output                                lr,
    output                                ws,
    output logic                          sck,
    output logic [board_pkg::w_mic - 1:0] value,
    output logic                          valid
);

    localparam half_period = clk_mhz / 6 > 1 ? clk_mhz / 6 : 1;
    localparam w_div       = $clog2 (half_period + 1);
    localparam w_mic       = board_pkg::w_mic;

    //----------------------------------------------------------------------

    logic [w_div - 1:0] div_cnt;
    logic [        5:0] bit_cnt;  // 64 sck periods per frame
    logic [w_mic - 1:0] shift;
    logic               last_bit;

    wire div_end  = div_cnt == w_div' (half_period - 1);
    wire sck_rise = div_end & ~ sck;
    wire sck_fall = div_end & sck;

    // Slot 0 is the I2S delay bit, slots 1 to 24 carry the sample
    wire capture  = sck_rise && bit_cnt >= 6'd1 && bit_cnt <= 6'd24;

    assign lr = 1'b0;        // Select the left channel
    assign ws = bit_cnt [5];  // Low for the left half of the frame

    //----------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            bit_cnt  <= '0;
            last_bit <= 1'b0;
            valid    <= 1'b0;
            value    <= '0;
        end
        else
        begin
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;

            if (div_end)
                sck <= ~ sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;  // ws changes with falling sck

            last_bit <= capture && bit_cnt == 6'd24;
            valid    <= last_bit;           // One clock after the LSB

            if (last_bit)
                value <= shift;
        end

    always_ff @ (posedge clk)
        if (capture)
            shift <= { shift [w_mic - 2:0], sd };  // MSB first

endmodule

/* src/i2s_audio_out.sv */
`timescale 1ns/1ns

module i2s_audio_out
#(
    parameter clk_mhz = 50
)
(
    input                                   clk,
    input                                   rst,
    input        [board_pkg::w_sound - 1:0] data_in,
    output logic                            mclk,
    output logic                            bclk,
    output                                  lrclk,
    output logic                            sdata
);

    localparam half_period = clk_mhz / 4 > 1 ? clk_mhz / 4 : 1;
    localparam w_div       = $clog2 (half_period + 1);
    localparam w_sound     = board_pkg::w_sound;

    //----------------------------------------------------------------------

    logic [w_div   - 1:0] div_cnt;
    logic [          4:0] bit_cnt;  // 16 bclk periods per channel
    logic [w_sound - 1:0] sample;
    logic [w_sound - 1:0] shreg;

    wire div_end     = div_cnt == w_div' (half_period - 1);
    wire bclk_fall   = div_end & bclk;
    wire frame_start = bclk_fall && bit_cnt == 5'd31;  // lrclk falls here

    assign lrclk = bit_cnt [4];

    //----------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bclk    <= 1'b0;
            bit_cnt <= '0;
            sample  <= '0;
            shreg   <= '0;
            sdata   <= 1'b0;
        end
        else
        begin
            mclk    <= ~ mclk;
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;

            if (div_end)
                bclk <= ~ bclk;

            if (frame_start)
                sample <= data_in;

            if (bclk_fall)
            begin
                bit_cnt <= bit_cnt + 1'b1;

                // One bclk after each lrclk edge the word starts again
                if (bit_cnt [3:0] == 4'd0)
                begin
                    sdata <= sample [w_sound - 1];
                    shreg <= { sample [w_sound - 2:0], 1'b0 };
                end
                else
                begin
                    sdata <= shreg [w_sound - 1];
                    shreg <= { shreg [w_sound - 2:0], 1'b0 };
                end
            end
        end

endmodule

/* src/lab_top.sv */
`timescale 1ns/1ns

module lab_top
#(
    parameter scan_w = 10
)
(
    input                                   clk,
    input                                   rst,
    input        [                     3:0] key,
    input        [                     8:0] sw,
    input        [board_pkg::w_mic   - 1:0] mic,
    input                                   mic_valid,
    output logic [board_pkg::w_bar   - 1:0] led,
    output logic [board_pkg::w_seg   - 1:0] abcdefgh,
    output logic [board_pkg::w_digit - 1:0] digit,
    output logic [board_pkg::w_sound - 1:0] sound
);

    localparam w_sound = board_pkg::w_sound;
    localparam w_digit = board_pkg::w_digit;

    logic [w_sound - 1:0] shown;      // Sample on the display
    logic                 shown_ok;   // Blank until the first sample
    logic [scan_w  - 1:0] scan_cnt;
    logic [w_sound - 1:0] magnitude;
    logic [          4:0] top_bit;
    logic [          3:0] nibble;

    wire  [w_sound - 1:0] live = mic [board_pkg::w_mic - 1 -: w_sound];

    //----------------------------------------------------------------------

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            shown    <= '0;
            shown_ok <= 1'b0;
            sound    <= '0;
        end
        else if (mic_valid)
        begin
            sound <= $signed (live) >>> sw [1:0];  // Volume

            if (~ key [0])  // key 0 freezes the display
            begin
                shown    <= live;
                shown_ok <= 1'b1;
            end
        end

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            scan_cnt <= '0;
            digit    <= w_digit' (1);
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;

            if (& scan_cnt)
                digit <= { digit [w_digit - 2:0], digit [w_digit - 1] };
        end

    //----------------------------------------------------------------------

    always_comb
    begin
        magnitude = shown [w_sound - 1] ? - shown : shown;
        top_bit   = '0;

        for (int i = 0; i < w_sound; i ++)
            if (magnitude [i])
                top_bit = 5' (i);

        // LED i lights when the top bit reaches 10 + i
        for (int i = 0; i < board_pkg::w_bar; i ++)
            led [i] = top_bit >= 5' (i + 10);
    end

    always_comb
    begin
        nibble   = '0;
        abcdefgh = '0;

        for (int k = 0; k < w_digit; k ++)
            if (digit [k])
                nibble = shown [k * 4 +: 4];

        if (shown_ok)
        begin
            abcdefgh     = board_pkg::seg_hex_font (nibble);
            abcdefgh [0] = digit [w_digit - 1] & shown [w_sound - 1];  // Sign point
        end
    end

endmodule

/* src/seg7_sticky_latch.sv */
`timescale 1ns/1ns

module seg7_sticky_latch
(
    input                                   clk,
    input                                   rst,
    input        [board_pkg::w_seg   - 1:0] hgfedcba,
    input        [board_pkg::w_digit - 1:0] digit,
    output       [                     6:0] hex0,
    output       [                     6:0] hex1,
    output       [                     6:0] hex2,
    output       [                     6:0] hex3,
    output logic [board_pkg::w_digit - 1:0] dp
);

    logic [6:0] hex_q [board_pkg::w_digit];

    // Each digit keeps its pattern until it is scanned again
    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            for (int k = 0; k < board_pkg::w_digit; k ++)
                hex_q [k] <= '1;  // Blank, active low

            dp <= '0;
        end
        else
        begin
            for (int k = 0; k < board_pkg::w_digit; k ++)
                if (digit [k])
                begin
                    hex_q [k] <= ~ hgfedcba [6:0];
                    dp    [k] <= hgfedcba [board_pkg::w_seg - 1];
                end
        end

    assign hex0 = hex_q [0];
    assign hex1 = hex_q [1];
    assign hex2 = hex_q [2];
    assign hex3 = hex_q [3];

endmodule

/* src/board_top.sv */
`timescale 1ns/1ns

module board_top
#(
    parameter clk_mhz = 50,
              scan_w  = 10
)
(
    input        clk,
    input  [3:0] KEY,        // Active low
    input  [9:0] SW,         // SW 9 is the reset
    input        mic_sd,
    output [9:0] LEDR,
    output [6:0] HEX0,
    output [6:0] HEX1,
    output [6:0] HEX2,
    output [6:0] HEX3,
    output       mic_lr,
    output       mic_ws,
    output       mic_sck,
    output       aud_mclk,
    output       aud_bclk,
    output       aud_lrclk,
    output       aud_sdata
);

    wire                              rst = SW [9];
    wire [                     3:0]   key = ~ KEY;
    wire [                     8:0]   sw  = SW [8:0];

    wire [board_pkg::w_mic   - 1:0]   mic;
    wire                              mic_valid;
    wire [board_pkg::w_sound - 1:0]   sound;
    wire [board_pkg::w_bar   - 1:0]   led;
    wire [board_pkg::w_seg   - 1:0]   abcdefgh;
    wire [board_pkg::w_seg   - 1:0]   hgfedcba;
    wire [board_pkg::w_digit - 1:0]   digit;
    wire [board_pkg::w_digit - 1:0]   dp;

    //----------------------------------------------------------------------

    inmp441_mic_i2s_receiver # (.clk_mhz (clk_mhz)) i_mic
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .sd    ( mic_sd    ),
        .lr    ( mic_lr    ),
        .ws    ( mic_ws    ),
        .sck   ( mic_sck   ),
        .value ( mic       ),
        .valid ( mic_valid )
    );

    lab_top # (.scan_w (scan_w)) i_lab_top
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .mic       ( mic       ),
        .mic_valid ( mic_valid ),
        .led       ( led       ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     ),
        .sound     ( sound     )
    );

    //----------------------------------------------------------------------

    // Segment a ends up on bit 0 to match the HEX pin order
    for (genvar i = 0; i < board_pkg::w_seg; i ++)
    begin : g_rev
        assign hgfedcba [i] = abcdefgh [board_pkg::w_seg - 1 - i];
    end

    seg7_sticky_latch i_latch
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hgfedcba ( hgfedcba ),
        .digit    ( digit    ),
        .hex0     ( HEX0     ),
        .hex1     ( HEX1     ),
        .hex2     ( HEX2     ),
        .hex3     ( HEX3     ),
        .dp       ( dp       )
    );

    assign LEDR = { dp, led };  // Upper four LEDs show the points

    i2s_audio_out # (.clk_mhz (clk_mhz)) i_audio
    (
        .clk     ( clk       ),
        .rst     ( rst       ),
        .data_in ( sound     ),
        .mclk    ( aud_mclk  ),
        .bclk    ( aud_bclk  ),
        .lrclk   ( aud_lrclk ),
        .sdata   ( aud_sdata )
    );

endmodule

/* bench/board_top_sva.sv */
`timescale 1ns/1ns

module board_top_sva
(
    input                            clk,
    input                            rst,
    input [board_pkg::w_digit - 1:0] digit,
    input                            strobe,
    input [                     6:0] hex0,
    input [                     6:0] hex1,
    input [                     6:0] hex2,
    input [                     6:0] hex3
);

    digit_one_hot: assert property (@ (posedge clk) disable iff (rst) $onehot (digit))
        else $error ("digit select is not one-hot: %b", digit);

    strobe_single: assert property (@ (posedge clk) disable iff (rst) strobe |=> ! strobe)
        else $error ("sample strobe high on two consecutive cycles");

    // A sticky digit may only move right after its own scan slot
    hex0_on_select: assert property (@ (posedge clk) disable iff (rst)
        $changed (hex0) |-> $past (digit [0]))
        else $error ("HEX0 changed while digit 0 was not selected");

    hex1_on_select: assert property (@ (posedge clk) disable iff (rst)
        $changed (hex1) |-> $past (digit [1]))
        else $error ("HEX1 changed while digit 1 was not selected");

    hex2_on_select: assert property (@ (posedge clk) disable iff (rst)
        $changed (hex2) |-> $past (digit [2]))
        else $error ("HEX2 changed while digit 2 was not selected");

    hex3_on_select: assert property (@ (posedge clk) disable iff (rst)
        $changed (hex3) |-> $past (digit [3]))
        else $error ("HEX3 changed while digit 3 was not selected");

endmodule

bind lab_top board_top_sva i_lab_sva
(
    .clk    ( clk       ),
    .rst    ( rst       ),
    .digit  ( digit     ),
    .strobe ( mic_valid ),
    .hex0   ( 7'h7f     ),  // No sticky outputs here
    .hex1   ( 7'h7f     ),
    .hex2   ( 7'h7f     ),
    .hex3   ( 7'h7f     )
);

bind seg7_sticky_latch board_top_sva i_latch_sva
(
    .clk    ( clk   ),
    .rst    ( rst   ),
    .digit  ( digit ),
    .strobe ( 1'b0  ),
    .hex0   ( hex0  ),
    .hex1   ( hex1  ),
    .hex2   ( hex2  ),
    .hex3   ( hex3  )
);

/* bench/tb_board_top.sv */
`timescale 1ns/1ns

module tb_board_top;

    localparam clk_mhz = 12;
    localparam scan_w  = 4;
    localparam timeout = 2000;  // Clock cycles allowed for one wait

    logic                            clk;
    logic [                     3:0] key_n;
    logic [                     9:0] sw;
    logic                            mic_sd     = 1'b0;
    logic [board_pkg::w_mic   - 1:0] mic_sample = '0;  // Sent by the microphone model
    logic [board_pkg::w_sound - 1:0] shown_exp  = '0;  // Expected on the display

    wire  [9:0] ledr;
    wire  [6:0] hex0;
    wire  [6:0] hex1;
    wire  [6:0] hex2;
    wire  [6:0] hex3;
    wire        mic_lr;
    wire        mic_ws;
    wire        mic_sck;
    wire        aud_mclk;
    wire        aud_bclk;
    wire        aud_lrclk;
    wire        aud_sdata;

    board_top # (.clk_mhz (clk_mhz), .scan_w (scan_w)) dut
    (
        .clk       ( clk       ),
        .KEY       ( key_n     ),
        .SW        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .LEDR      ( ledr      ),
        .HEX0      ( hex0      ),
        .HEX1      ( hex1      ),
        .HEX2      ( hex2      ),
        .HEX3      ( hex3      ),
        .mic_lr    ( mic_lr    ),
        .mic_ws    ( mic_ws    ),
        .mic_sck   ( mic_sck   ),
        .aud_mclk  ( aud_mclk  ),
        .aud_bclk  ( aud_bclk  ),
        .aud_lrclk ( aud_lrclk ),
        .aud_sdata ( aud_sdata )
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~ clk;
    end

    //----------------------------------------------------------------------
    // Microphone model and audio deserializer
    //----------------------------------------------------------------------

    int                              mic_slot   = 0;
    logic                            prev_ws    = 1'b0;
    logic                            prev_sck   = 1'b0;
    logic                            prev_bclk  = 1'b0;
    logic                            last_lr    = 1'b0;
    logic [board_pkg::w_sound - 1:0] aud_shift  = '0;
    logic [board_pkg::w_sound - 1:0] left_word  = '0;
    logic [board_pkg::w_sound - 1:0] right_word = '0;
    int                              left_cnt   = 0;
    int                              right_cnt  = 0;

    always @ (negedge clk)
    begin
        if (sw [9] || (prev_ws && ! mic_ws))
            mic_slot = 0;                         // Left half opens with the delay slot
        else if (prev_sck && ! mic_sck && ! mic_ws)
            mic_slot = mic_slot + 1;              // New bit after each falling sck

        if (mic_slot >= 1 && mic_slot <= board_pkg::w_mic)
            mic_sd = mic_sample [board_pkg::w_mic - mic_slot];
        else
            mic_sd = 1'b0;

        prev_ws  = mic_ws;
        prev_sck = mic_sck;
    end

    always @ (negedge clk)
    begin
        if (! prev_bclk && aud_bclk)
        begin
            aud_shift = { aud_shift [board_pkg::w_sound - 2:0], aud_sdata };

            // The LSB arrives one bclk after lrclk has moved on
            if (aud_lrclk != last_lr)
            begin
                if (last_lr)
                begin
                    right_word = aud_shift;
                    right_cnt  = right_cnt + 1;
                end
                else
                begin
                    left_word = aud_shift;
                    left_cnt  = left_cnt + 1;
                end

                last_lr = aud_lrclk;
            end
        end

        prev_bclk = aud_bclk;
    end

    //----------------------------------------------------------------------
    // Expected values and checks
    //----------------------------------------------------------------------

    // Bit 6 is segment g, bit 0 is segment a, a lit segment is low
    function automatic logic [6:0] hex_low (input logic [3:0] nibble);
        case (nibble)
            4'h0: hex_low = 7'b100_0000;
            4'h1: hex_low = 7'b111_1001;
            4'h2: hex_low = 7'b010_0100;
            4'h3: hex_low = 7'b011_0000;
            4'h4: hex_low = 7'b001_1001;
            4'h5: hex_low = 7'b001_0010;
            4'h6: hex_low = 7'b000_0010;
            4'h7: hex_low = 7'b111_1000;
            4'h8: hex_low = 7'b000_0000;
            4'h9: hex_low = 7'b001_0000;
            4'ha: hex_low = 7'b000_1000;
            4'hb: hex_low = 7'b000_0011;
            4'hc: hex_low = 7'b100_0110;
            4'hd: hex_low = 7'b010_0001;
            4'he: hex_low = 7'b000_0110;
            default: hex_low = 7'b000_1110;
        endcase
    endfunction

    task automatic stop_on_error (input string msg);
        $display ("%s", msg);
        $display ("Result: FAILED");
        $fatal (1, "Simulation stopped at the first error");
    endtask

    task automatic check_hex
    (
        input string           name,
        input logic [3:0][6:0] expected,
        input logic [3:0][6:0] actual
    );
        for (int k = 0; k < board_pkg::w_digit; k ++)
            if (actual [k] !== expected [k])
                stop_on_error ($sformatf ("Mismatch %s HEX%0d: expected %b actual %b",
                    name, k, expected [k], actual [k]));
    endtask

    task automatic check_sound
    (
        input string                           name,
        input logic [board_pkg::w_sound - 1:0] expected,
        input logic [board_pkg::w_sound - 1:0] actual
    );
        if (actual !== expected)
            stop_on_error ($sformatf ("Mismatch %s audio word: expected %h actual %h",
                name, expected, actual));
    endtask

    task automatic check_leds (input string name, input logic [9:0] expected,
        input logic [9:0] actual);
        if (actual !== expected)
            stop_on_error ($sformatf ("Mismatch %s LEDR: expected %b actual %b",
                name, expected, actual));
    endtask

    task automatic check_pin
    (
        input string name,
        input logic  expected,
        input logic  actual
    );
        if (actual !== expected)
            stop_on_error ($sformatf ("Mismatch %s pin: expected %b actual %b",
                name, expected, actual));
    endtask

    logic mclk_exp = 1'b0;  // Master clock runs at half the system clock

    always @ (posedge clk)
        mclk_exp <= sw [9] ? 1'b0 : ~ mclk_exp;

    always @ (negedge clk)
        if (! sw [9])
        begin
            check_pin ("aud_mclk", mclk_exp, aud_mclk);
            check_pin ("mic_lr", 1'b0, mic_lr);  // Left channel select
        end

    task automatic wait_for_samples (input int count);
        int seen   = 0;
        int cycles = 0;

        while (seen < count)
        begin
            @ (negedge clk);
            cycles ++;

            if (dut.mic_valid)
                seen ++;

            if (cycles > timeout)
                stop_on_error ("Timeout while waiting for a microphone sample");
        end
    endtask

    task automatic settle_display ();
        logic [board_pkg::w_digit - 1:0] seen   = '0;
        int                              cycles = 0;

        @ (negedge clk);

        while (seen != '1)
        begin
            @ (negedge clk);
            seen = seen | dut.digit;
            cycles ++;

            if (cycles > timeout)
                stop_on_error ("Timeout while waiting for a full digit scan");
        end

        @ (negedge clk);  // Last digit reaches its latch
    endtask

    task automatic catch_audio_words ();
        int left_snap  = left_cnt;
        int right_snap = 0;
        int cycles     = 0;

        // The first left word may still carry the older sample
        while (left_cnt < left_snap + 2)
        begin
            @ (negedge clk);
            cycles ++;

            if (cycles > timeout)
                stop_on_error ("Timeout while waiting for a left audio word");
        end

        right_snap = right_cnt;
        cycles     = 0;

        while (right_cnt < right_snap + 1)
        begin
            @ (negedge clk);
            cycles ++;

            if (cycles > timeout)
                stop_on_error ("Timeout while waiting for a right audio word");
        end
    endtask

    task automatic run_pattern
    (
        input string                           name,
        input logic [board_pkg::w_mic   - 1:0] sample,
        input int                              volume,
        input int                              freeze,
        input logic [board_pkg::w_sound - 1:0] exp_sound,
        input logic [                     9:0] exp_leds
    );
        logic [3:0][6:0] exp_hex;

        @ (negedge clk);
        mic_sample = sample;
        sw [1:0]   = 2' (volume);
        key_n [0]  = freeze == 0;  // Pressed key reads low

        if (freeze == 0)
            shown_exp = sample [board_pkg::w_mic - 1 -: board_pkg::w_sound];

        for (int k = 0; k < board_pkg::w_digit; k ++)
            exp_hex [k] = hex_low (shown_exp [k * 4 +: 4]);

        wait_for_samples (2);  // The first one may straddle the change
        settle_display ();
        check_hex (name, exp_hex, { hex3, hex2, hex1, hex0 });
        check_leds (name, exp_leds, ledr);

        catch_audio_words ();
        check_sound ({ name, " left" }, exp_sound, left_word);
        check_sound ({ name, " right" }, exp_sound, right_word);
        $display ("Pattern %s checked", name);
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------

    initial
    begin
        int                              fd;
        int                              fields;
        int                              volume;
        int                              freeze;
        int                              tests;
        string                           line;
        string                           name;
        logic [board_pkg::w_mic   - 1:0] sample;
        logic [board_pkg::w_sound - 1:0] exp_sound;
        logic [                     9:0] exp_leds;

        tests = 0;
        key_n = 4'hf;     // All keys released
        sw    = 10'h200;  // Reset switch up

        repeat (4)
            @ (negedge clk);

        sw [9] = 1'b0;

        settle_display ();
        check_hex ("reset", { 4 { 7'h7f } }, { hex3, hex2, hex1, hex0 });
        check_leds ("reset", 10'h000, ledr);

        fd = $fopen ("bench/mic_patterns.txt", "r");

        if (fd == 0)
            stop_on_error ("Cannot open the pattern file bench/mic_patterns.txt");

        while ($fgets (line, fd) > 0)
        begin
            fields = $sscanf (line, "%s %h %d %d %h %h",
                name, sample, volume, freeze, exp_sound, exp_leds);

            if (line [0] != "#" && fields == 6)
            begin
                run_pattern (name, sample, volume, freeze, exp_sound, exp_leds);
                tests ++;
            end
        end

        $fclose (fd);

        if (tests == 0)
            stop_on_error ("The pattern file holds no test line");

        $display ("Result: PASSED");
        $finish;
    end

endmodule

/* files.f */
src/board_pkg.sv
src/inmp441_mic_i2s_receiver.sv
src/i2s_audio_out.sv
src/lab_top.sv
src/seg7_sticky_latch.sv
src/board_top.sv
bench/board_top_sva.sv
bench/tb_board_top.sv

/* Makefile */
TOP = tb_board_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f src/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

/* bench/mic_patterns.txt */
# name         mic_sample  volume  freeze  sound  ledr
# Sample, sound and ledr in hex; volume is SW[1:0]; freeze 1 holds KEY[0] pressed
pos_small      012345      0       0       0123   000
neg_mid        abcdef      1       0       d5e6   21f
pos_level      7fff00      2       0       1fff   01f
neg_full       800000      3       0       f000   23f
freeze_hold    1234aa      0       1       1234   23f
level_one      0400ff      0       0       0400   001
neg_small      fff000      2       0       fffc   200
level_three    0c5a00      1       0       062d   003
freeze_neg     9abc12      0       1       9abc   003
all_zero       000000      3       0       0000   000
